// File: hw/ackMerge.sv
/* Acknowledge merge: combines all acknowledges and the unclaimed-cycle timeout,
   drives TA, TCI and ROM enable levels with their output enables */
`timescale 1ns/10ps

module ackMerge (
    input  logic                  CLK40,
    input  logic                  nRESET,
    input  busAckPkg::timerMaskT  timerAck,
    input  logic                  ciaAck,
    input  logic                  idleStart,
    input  busAckPkg::spaceCodeT  spaceCode,
    output logic                  cycleDone,
    output logic                  nTA,
    output logic                  taEnable,
    output logic                  nTCI,
    output logic                  tciEnable,
    output logic                  nROMEN
);

    import busAckPkg::*;

    logic       timeoutRun;
    timeoutCntT timeoutCnt;
    logic       timeoutAck;
    logic       ackLevel;
    logic       inhibitSpace;
    logic       holdHigh;
    logic       holdInhibit;

    //////////////////////////////
    // Unclaimed-cycle timeout
    //////////////////////////////

    // Nothing answers an unmapped address, so end the cycle ourselves
    always_ff @(posedge CLK40, negedge nRESET) begin
        if (!nRESET) begin
            timeoutRun <= 1'b0;
            timeoutCnt <= '0;
        end else if (idleStart) begin
            timeoutRun <= 1'b1;
            timeoutCnt <= timeoutCntT'(TIMEOUT_CYCLES - 1);
        end else if (timeoutRun) begin
            if (timeoutCnt == '0) begin
                timeoutRun <= 1'b0;
            end else begin
                timeoutCnt <= timeoutCnt - timeoutCntT'(1);
            end
        end
    end

    assign timeoutAck = timeoutRun && (timeoutCnt == '0);

    //////////////////////////////
    // Acknowledge and hold
    //////////////////////////////

    assign ackLevel  = (|timerAck) || ciaAck || timeoutAck;
    assign cycleDone = ackLevel;

    // CIA and IO must never be cached
    assign inhibitSpace = (spaceCode == SPACE_CIA) || (spaceCode == SPACE_IO);

    // One extra cycle of driven-high TA so the next cycle cannot end early
    always_ff @(posedge CLK40, negedge nRESET) begin
        if (!nRESET) begin
            holdHigh    <= 1'b0;
            holdInhibit <= 1'b0;
        end else begin
            holdHigh    <= ackLevel;
            holdInhibit <= ackLevel && inhibitSpace;
        end
    end

    // Levels and their drive enables
    assign nTA       = holdHigh || !ackLevel;
    assign taEnable  = (spaceCode != SPACE_NONE) || holdHigh;
    assign nTCI      = !(ackLevel && inhibitSpace);
    assign tciEnable = inhibitSpace || holdInhibit;
    assign nROMEN    = (spaceCode != SPACE_ROM);

endmodule

// File: hw/busAckPkg.sv
/* Shared definitions for the transfer-acknowledge block: space codes, wait-state
   table, timeout length and the vector types used on the ports */
package busAckPkg;

    // Full 68040 bus address
    typedef logic [31:0] busAddrT;

    // Decoded address space, held for the length of one bus cycle
    typedef logic [2:0] spaceCodeT;

    localparam spaceCodeT SPACE_NONE     = 3'd0;
    localparam spaceCodeT SPACE_ROM      = 3'd1;
    localparam spaceCodeT SPACE_IO       = 3'd2;
    localparam spaceCodeT SPACE_CONFIG   = 3'd3;
    localparam spaceCodeT SPACE_CIA      = 3'd4;
    localparam spaceCodeT SPACE_UNMAPPED = 3'd5;

    ////////////////////////////////
    // Decode rule, address bits 23..16
    //   F8..FF  ROM
    //   BF      CIA
    //   DA..DF  IO
    //   E8      CONFIG
    //   others  unmapped, ended by the timeout
    // CIA and IO cycles are cache inhibited, all other spaces may be cached
    ////////////////////////////////

    // Timed spaces, timer i serves space code i+1
    localparam int NUM_TIMERS = 3;

    // One bit per wait-state timer
    typedef logic [NUM_TIMERS-1:0] timerMaskT;

    // One wait-state count
    typedef logic [3:0] delayT;

    // Wait states per timer: ROM, IO, CONFIG
    // ROM gets the longest delay to cover the ROM setup time
    localparam delayT WAIT_STATES [NUM_TIMERS] = '{4'd5, 4'd2, 4'd3};

    // Cycles before an unclaimed cycle is acknowledged
    localparam int TIMEOUT_CYCLES = 32;
    localparam int TIMEOUT_WIDTH  = $clog2(TIMEOUT_CYCLES);

    // Down-counter for the unclaimed-cycle timeout
    typedef logic [TIMEOUT_WIDTH-1:0] timeoutCntT;

endpackage

// File: hw/ciaCycleSync.sv
/* CIA cycle termination: follows the slow CIA clock and acknowledges after
   a falling edge of it */
`timescale 1ns/10ps

module ciaCycleSync (
    input  logic  CLK40,
    input  logic  nRESET,
    input  logic  CLKCIA,
    input  logic  start,
    output logic  ack
);

    typedef enum logic [1:0] {
        CIA_IDLE,
        CIA_WAIT_HIGH,
        CIA_WAIT_LOW
    } ciaStateT;

    ciaStateT   state;
    logic [1:0] lastClk;

    //////////////////////////////
    // CIA clock history and FSM
    //////////////////////////////

    // The CIA latches its chip select on the clock edge, so we must end the
    // cycle only once the clock has gone high and then settled low again
    always_ff @(posedge CLK40, negedge nRESET) begin
        if (!nRESET) begin
            lastClk <= 2'b00;
            state   <= CIA_IDLE;
            ack     <= 1'b0;
        end else begin
            // Two-sample history of the CIA clock
            lastClk <= {lastClk[0], CLKCIA};
            ack     <= 1'b0;

            case (state)
                CIA_IDLE: begin
                    if (start) begin
                        state <= CIA_WAIT_HIGH;
                    end
                end
                CIA_WAIT_HIGH: begin
                    // Arm on two high samples
                    if (lastClk == 2'b11) begin
                        state <= CIA_WAIT_LOW;
                    end
                end
                CIA_WAIT_LOW: begin
                    // Two low samples, falling edge is behind us
                    if (lastClk == 2'b00) begin
                        ack   <= 1'b1;
                        state <= CIA_IDLE;
                    end
                end
                default: begin
                    state <= CIA_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/spaceDecoder.sv
/* Address space decoder: registers the space at transfer start, holds it
   until the cycle ends and fires the matching start strobe */
`timescale 1ns/10ps

module spaceDecoder (
    input  logic                  CLK40,
    input  logic                  nRESET,
    input  logic                  TS,
    input  busAckPkg::busAddrT    ADDR,
    input  logic                  cycleDone,
    output busAckPkg::spaceCodeT  spaceCode,
    output busAckPkg::timerMaskT  timerStart,
    output logic                  ciaStart,
    output logic                  idleStart
);

    import busAckPkg::*;

    spaceCodeT newCode;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    // Only bits 23..16 take part in the decode
    function automatic spaceCodeT decodeSpace(input logic [7:0] hiAddr);
        spaceCodeT code;
        if (hiAddr >= 8'hF8) begin
            code = SPACE_ROM;
        end else if (hiAddr == 8'hBF) begin
            code = SPACE_CIA;
        end else if ((hiAddr >= 8'hDA) && (hiAddr <= 8'hDF)) begin
            code = SPACE_IO;
        end else if (hiAddr == 8'hE8) begin
            code = SPACE_CONFIG;
        end else begin
            code = SPACE_UNMAPPED;
        end
        return code;
    endfunction

    assign newCode = decodeSpace(ADDR[23:16]);

    //////////////////////////////
    // Held space and start strobes
    //////////////////////////////

    always_ff @(posedge CLK40, negedge nRESET) begin
        if (!nRESET) begin
            spaceCode  <= SPACE_NONE;
            timerStart <= '0;
            ciaStart   <= 1'b0;
            idleStart  <= 1'b0;
        end else begin
            // Strobes last one cycle
            timerStart <= '0;
            ciaStart   <= 1'b0;
            idleStart  <= 1'b0;

            if (cycleDone) begin
                // Cycle ended, free the decoder
                spaceCode <= SPACE_NONE;
            end else if (TS && (spaceCode == SPACE_NONE)) begin
                // A TS while a cycle is held falls through here and is dropped
                spaceCode <= newCode;
                case (newCode)
                    SPACE_ROM, SPACE_IO, SPACE_CONFIG: begin
                        // Timer index is space code minus one
                        timerStart <= timerMaskT'(1) << (newCode - SPACE_ROM);
                    end
                    SPACE_CIA: begin
                        ciaStart <= 1'b1;
                    end
                    default: begin
                        idleStart <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

// File: hw/transferAckTop.sv
/* Transfer-acknowledge top: space decoder, wait-state timers, CIA sync
   and acknowledge merge */
`timescale 1ns/10ps

module transferAckTop (
    input  logic                CLK40,
    input  logic                nRESET,
    input  logic                TS,
    input  busAckPkg::busAddrT  ADDR,
    input  logic                CLKCIA,
    output logic                nTA,
    output logic                taEnable,
    output logic                nTCI,
    output logic                tciEnable,
    output logic                nROMEN
);

    import busAckPkg::*;

    spaceCodeT spaceCode;
    timerMaskT timerStart;
    timerMaskT timerAck;
    logic      ciaStart;
    logic      idleStart;
    logic      ciaAck;
    logic      cycleDone;

    //////////////////////////////
    // Decode
    //////////////////////////////

    spaceDecoder decoder (
        .CLK40      (CLK40),
        .nRESET     (nRESET),
        .TS         (TS),
        .ADDR       (ADDR),
        .cycleDone  (cycleDone),
        .spaceCode  (spaceCode),
        .timerStart (timerStart),
        .ciaStart   (ciaStart),
        .idleStart  (idleStart)
    );

    //////////////////////////////
    // Timed spaces
    //////////////////////////////

    // One timer per timed space, delay from the package table
    for (genvar i = 0; i < NUM_TIMERS; i++) begin : genTimer
        waitStateTimer timer (
            .CLK40  (CLK40),
            .nRESET (nRESET),
            .start  (timerStart[i]),
            .delay  (WAIT_STATES[i]),
            .ack    (timerAck[i])
        );
    end

    // CIA space
    ciaCycleSync ciaSync (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .CLKCIA (CLKCIA),
        .start  (ciaStart),
        .ack    (ciaAck)
    );

    // Output levels
    ackMerge merge (
        .CLK40     (CLK40),
        .nRESET    (nRESET),
        .timerAck  (timerAck),
        .ciaAck    (ciaAck),
        .idleStart (idleStart),
        .spaceCode (spaceCode),
        .cycleDone (cycleDone),
        .nTA       (nTA),
        .taEnable  (taEnable),
        .nTCI      (nTCI),
        .tciEnable (tciEnable),
        .nROMEN    (nROMEN)
    );

endmodule

// File: hw/waitStateTimer.sv
/* Wait-state timer: acknowledges a fixed number of cycles after its start
   strobe, delay given per instance */
`timescale 1ns/10ps

module waitStateTimer (
    input  logic              CLK40,
    input  logic              nRESET,
    input  logic              start,
    input  busAckPkg::delayT  delay,
    output logic              ack
);

    import busAckPkg::*;

    typedef enum logic {
        TIMER_IDLE,
        TIMER_COUNT
    } timerStateT;

    timerStateT state;
    delayT      count;

    //////////////////////////////
    // Down-counter FSM
    //////////////////////////////

    // Loaded with delay-1 on the start edge, so a zero count
    // lands exactly delay cycles after the start strobe
    always_ff @(posedge CLK40, negedge nRESET) begin
        if (!nRESET) begin
            state <= TIMER_IDLE;
            count <= '0;
        end else begin
            case (state)
                TIMER_IDLE: begin
                    if (start) begin
                        count <= delay - delayT'(1);
                        state <= TIMER_COUNT;
                    end
                end
                TIMER_COUNT: begin
                    if (count == '0) begin
                        // Expired this cycle, ack is out now
                        state <= TIMER_IDLE;
                    end else begin
                        count <= count - delayT'(1);
                    end
                end
                default: begin
                    state <= TIMER_IDLE;
                end
            endcase
        end
    end

    // One-cycle pulse on expiry, decoded from registers only
    assign ack = (state == TIMER_COUNT) && (count == '0);

endmodule

// File: runSim.sh
#!/usr/bin/env bash
# Builds the transfer-acknowledge testbench with Verilator and runs it.
# Exit status is zero only when the run reports a pass.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project root"
    exit 1
fi

verilator --binary --timing -f vlog.f --top-module transferAckTb -Mdir obj_dir -o simTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

echo "$output" | grep -qx "Simulation PASSED"
if [ $? -ne 0 ]; then
    echo "Pass message not found in the simulation output"
    exit 1
fi

exit 0

// File: tests/ackInput.txt
// Bus cycles, one per line, all fields hex
// address  space code  cache-inhibit bit  timed-space flag
00F80000 1 0 1
00DA0000 2 1 1
00E80000 3 0 1
00BFE001 4 1 0
00000004 5 0 0
00FC1234 1 0 1
00DC0004 2 1 1
00BFD000 4 1 0
00E80048 3 0 1
00D90000 5 0 0
00FFFFFC 1 0 1
00DD2020 2 1 1
00BFE101 4 1 0
40E8FFFC 3 0 1
00E00000 5 0 0
FFF80010 1 0 1
00DFF000 2 1 1
12BF0F00 4 1 0
00E90000 5 0 0
00FA0100 1 0 1
00DB8000 2 1 1
00BFE201 4 1 0
00E80010 3 0 1
00F70000 5 0 0
00FE0000 1 0 1
00DE0040 2 1 1
00BFD100 4 1 0
00BE0000 5 0 0
00E80020 3 0 1
00F90000 1 0 1
00C00000 5 0 0
00BFE301 4 1 0
00DAFFFC 2 1 1
00C0FFFF 5 0 0
00E8FF00 3 0 1
00BFD200 4 1 0

// File: tests/transferAckTb.sv
/* Testbench for the transfer-acknowledge block that reads bus cycles from the data
   file, drives TS and the CIA clock and checks TA, TCI and ROM enable */
`timescale 1ns/10ps

module transferAckTb;

    import busAckPkg::*;

    localparam int MAX_TESTS  = 64;
    localparam int WAIT_LIMIT = TIMEOUT_CYCLES + 64;
    localparam int CIA_PERIOD = 24;

    logic    CLK40  = 1'b0;
    logic    nRESET = 1'b0;
    logic    TS     = 1'b0;
    busAddrT ADDR   = '0;
    logic    CLKCIA = 1'b0;
    logic    nTA;
    logic    taEnable;
    logic    nTCI;
    logic    tciEnable;
    logic    nROMEN;

    // Four words per cycle hold address, space, inhibit bit and timed flag
    logic [31:0] stimMem [0:MAX_TESTS*4-1];
    logic        ciaSamples [$];
    logic [31:0] lfsrState   = 32'h763a0bbf;
    int          numTests    = 0;
    int          errorCount  = 0;
    int          failedTests = 0;
    int          clkCount    = 0;
    int          ciaPhase    = 0;
    logic        loaded      = 1'b0;

    transferAckTop UUT (
        .CLK40     (CLK40),
        .nRESET    (nRESET),
        .TS        (TS),
        .ADDR      (ADDR),
        .CLKCIA    (CLKCIA),
        .nTA       (nTA),
        .taEnable  (taEnable),
        .nTCI      (nTCI),
        .tciEnable (tciEnable),
        .nROMEN    (nROMEN)
    );

    //////////////////////////////
    // Clocks
    //////////////////////////////

    always #2 CLK40 = ~CLK40;

    // CIA clock divided from CLK40 with its phase set once from the LFSR
    always @(posedge CLK40) begin
        clkCount <= clkCount + 1;
        CLKCIA   <= ((clkCount + ciaPhase) % CIA_PERIOD) < (CIA_PERIOD / 2);
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // One LFSR step per bit taken
    function automatic int drawBits(input int count);
        int value;
        value = 0;
        for (int b = 0; b < count; b++) begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
        return value;
    endfunction

    // Address map on bits 23..16
    function automatic spaceCodeT decodeAddr(input busAddrT addr);
        logic [7:0] hi;
        spaceCodeT  space;
        hi = addr[23:16];
        case (hi) inside
            [8'hF8:8'hFF]: space = SPACE_ROM;
            8'hBF:         space = SPACE_CIA;
            [8'hDA:8'hDF]: space = SPACE_IO;
            8'hE8:         space = SPACE_CONFIG;
            default:       space = SPACE_UNMAPPED;
        endcase
        return space;
    endfunction

    // Chip registers must not be cached
    function automatic logic inhibitRule(input spaceCodeT space);
        return (space == SPACE_CIA) || (space == SPACE_IO);
    endfunction

    // True when sample n-4 ends a high phase, n-3 and n-2 are low,
    // and a pair of high samples was seen since TS
    function automatic logic ciaAckDue(input int n);
        logic pairSeen;
        pairSeen = 1'b0;
        if (n < 5) begin
            return 1'b0;
        end
        for (int a = 0; a + 1 <= n - 4; a++) begin
            if (ciaSamples[a] && ciaSamples[a + 1]) begin
                pairSeen = 1'b1;
            end
        end
        return pairSeen && ciaSamples[n - 4] && !ciaSamples[n - 3] && !ciaSamples[n - 2];
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            errorCount++;
        end
    endtask

    //////////////////////////////
    // One bus cycle
    //////////////////////////////

    task automatic runCycle(input int index);
        busAddrT   addr;
        busAddrT   extraAddr;
        spaceCodeT expSpace;
        logic      expTci;
        logic      expTimed;
        int        expCycle;
        int        ackCycle;
        int        n;
        int        errBefore;

        addr      = stimMem[index*4];
        expSpace  = stimMem[index*4 + 1][2:0];
        expTci    = stimMem[index*4 + 2][0];
        expTimed  = stimMem[index*4 + 3][0];
        errBefore = errorCount;
        expCycle  = 0;
        ackCycle  = 0;
        n         = 0;
        // A dropped TS from another space would show on nROMEN or tciEnable
        extraAddr = (expSpace == SPACE_ROM) ? 32'h00DA0000 : 32'h00F80000;

        // Data file against the address map
        checkValue("decoded space", 32'(decodeAddr(addr)), 32'(expSpace));
        checkValue("cache-inhibit bit", 32'(inhibitRule(expSpace)), 32'(expTci));
        checkValue("timed flag", 32'(expSpace inside {SPACE_ROM, SPACE_IO, SPACE_CONFIG}),
                   32'(expTimed));

        // Latency counted from the edge where TS is seen
        case (expSpace)
            SPACE_ROM:      expCycle = 1 + int'(WAIT_STATES[0]);
            SPACE_IO:       expCycle = 1 + int'(WAIT_STATES[1]);
            SPACE_CONFIG:   expCycle = 1 + int'(WAIT_STATES[2]);
            SPACE_UNMAPPED: expCycle = 1 + TIMEOUT_CYCLES;
            default:        expCycle = 0;
        endcase

        TS   <= 1'b1;
        ADDR <= addr;
        @(posedge CLK40);
        TS <= 1'b0;
        ciaSamples.delete();
        ciaSamples.push_back(CLKCIA);
        checkValue("nTA before start", 32'(nTA), 32'd1);
        checkValue("taEnable before start", 32'(taEnable), 32'd0);

        while ((ackCycle == 0) && (n < WAIT_LIMIT)) begin
            @(posedge CLK40);
            n++;
            // Second TS lands while the cycle is held
            if (n == 1) begin
                TS   <= 1'b1;
                ADDR <= extraAddr;
            end else if (n == 2) begin
                TS <= 1'b0;
            end
            if ((expSpace == SPACE_CIA) && (expCycle == 0) && ciaAckDue(n)) begin
                expCycle = n;
            end
            ciaSamples.push_back(CLKCIA);
            checkValue("taEnable during cycle", 32'(taEnable), 32'd1);
            checkValue("tciEnable during cycle", 32'(tciEnable), 32'(expTci));
            checkValue("nROMEN during cycle", 32'(nROMEN), 32'(expSpace != SPACE_ROM));
            if (!nTA) begin
                ackCycle = n;
                checkValue("acknowledge cycle", n, expCycle);
                checkValue("nTCI with nTA", 32'(nTCI), 32'(!expTci));
            end else begin
                checkValue("nTCI without nTA", 32'(nTCI), 32'd1);
            end
        end

        if (ackCycle == 0) begin
            $display("Test %0d: no acknowledge within %0d cycles for address %h",
                     index, WAIT_LIMIT, addr);
            errorCount++;
        end else begin
            // TA driven high for one cycle
            @(posedge CLK40);
            checkValue("nTA in hold cycle", 32'(nTA), 32'd1);
            checkValue("taEnable in hold cycle", 32'(taEnable), 32'd1);
            checkValue("nTCI in hold cycle", 32'(nTCI), 32'd1);
            checkValue("tciEnable in hold cycle", 32'(tciEnable), 32'(expTci));
            checkValue("nROMEN in hold cycle", 32'(nROMEN), 32'd1);
            // Released and the dropped TS starts nothing
            repeat (4) begin
                @(posedge CLK40);
                checkValue("nTA after release", 32'(nTA), 32'd1);
                checkValue("taEnable after release", 32'(taEnable), 32'd0);
                checkValue("nTCI after release", 32'(nTCI), 32'd1);
                checkValue("tciEnable after release", 32'(tciEnable), 32'd0);
                checkValue("nROMEN after release", 32'(nROMEN), 32'd1);
            end
        end

        if (errorCount != errBefore) begin
            failedTests++;
        end
        $display("Test %0d addr %h space %0d latency %0d: %s", index, addr, expSpace,
                 ackCycle, (errorCount == errBefore) ? "ok" : "fail");
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int gap;
        int errBefore;
        // Unwritten words keep their inverted address that no space code can match
        for (int i = 0; i < MAX_TESTS*4; i++) begin
            stimMem[i] = ~32'(i);
        end
        $readmemh("tests/ackInput.txt", stimMem);
        while ((numTests < MAX_TESTS) &&
               (stimMem[numTests*4 + 1] != ~32'(numTests*4 + 1))) begin
            numTests++;
        end
        ciaPhase = drawBits(5) % CIA_PERIOD;
        loaded   = 1'b1;

        // Reset state is checked while nRESET is still low
        errBefore = errorCount;
        repeat (6) @(posedge CLK40);
        checkValue("nTA in reset", 32'(nTA), 32'd1);
        checkValue("nTCI in reset", 32'(nTCI), 32'd1);
        checkValue("nROMEN in reset", 32'(nROMEN), 32'd1);
        checkValue("taEnable in reset", 32'(taEnable), 32'd0);
        checkValue("tciEnable in reset", 32'(tciEnable), 32'd0);
        if (errorCount != errBefore) begin
            failedTests++;
        end
        $display("Reset check: %s", (errorCount == errBefore) ? "ok" : "fail");
        repeat (2) @(posedge CLK40);
        nRESET <= 1'b1;
        @(posedge CLK40);

        for (int i = 0; i < numTests; i++) begin
            // Random idle gap moves each cycle against the CIA clock
            gap = drawBits(2);
            repeat (gap) @(posedge CLK40);
            runCycle(i);
        end

        $display("Tests run %0d, failed %0d, mismatches %0d", numTests + 1, failedTests,
                 errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog allows 100 cycles per data line
    initial begin
        wait (loaded);
        repeat (numTests * 100) @(posedge CLK40);
        $display("Watchdog: run did not finish within %0d cycles", numTests * 100);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: vlog.f
hw/busAckPkg.sv
hw/spaceDecoder.sv
hw/waitStateTimer.sv
hw/ciaCycleSync.sv
hw/ackMerge.sv
hw/transferAckTop.sv
tests/transferAckTb.sv
